// ==== common/fetch_pkg.sv ====
/* fetch package: widths, instruction constants and state encoding
   shared by the instruction fetch unit and its bus master */
`default_nettype none

package fetch_pkg;

	// data and address width of the core
	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] data_t;
	typedef logic [31:0]     instr_t;

	// external boot address, zero-extended into the pc
	typedef logic [9:0] boot_pc_t;

	// AXI-Lite read response code
	typedef logic [1:0] axil_resp_t;

	// four queue entries
	localparam int QUEUE_ADDR_WIDTH = 2;

	// entry count at which fetch pauses
	localparam int QUEUE_ALMOST_FULL = 2;

	// addi x0, x0, 0
	localparam instr_t NOP = 32'h00000013;

	localparam instr_t ECALL = 32'h00000073;

	// bus words arrive with their four bytes reversed
	localparam bit INSTR_BYTE_SWAP = 1'b1;

	// IDLE    waiting for go from the debugger
	// FETCH   requesting words
	// HOLD    queue almost full, no new requests
	// ECALL_WAIT  ecall fetched, waiting for it to retire
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		HOLD,
		ECALL_WAIT
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== fetch/fetch_unit.sv ====
/* fetch unit: pc control, fetch state machine and redirect handling,
   issuing queued instructions to decode with byte order restored */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         go,
	input  wire fetch_pkg::boot_pc_t    boot_pc,
	input  wire                         stall,
	input  wire                         flush,
	input  wire fetch_pkg::data_t       target,
	input  wire fetch_pkg::instr_t      retire_instr,
	input  wire                         busy,
	input  wire                         done,
	input  wire fetch_pkg::data_t       rd_data,
	output logic                        req,
	output fetch_pkg::data_t            req_addr,
	output fetch_pkg::instr_t           instr,
	output fetch_pkg::data_t            pc,
	output logic                        instr_valid
);

	// put a bus word back into instruction byte order
	function automatic fetch_pkg::instr_t fix_order(input fetch_pkg::data_t word);
		if (fetch_pkg::INSTR_BYTE_SWAP)
			return {word[7:0], word[15:8], word[23:16], word[31:24]};
		else
			return fetch_pkg::instr_t'(word);
	endfunction

	fetch_pkg::fetch_state_t state;
	fetch_pkg::fetch_state_t state_nxt;
	fetch_pkg::data_t        fetch_pc;
	logic                    redirect_pending;
	logic                    accept;
	logic                    fetched_ecall;
	logic                    q_rd_en;
	logic                    q_empty;
	logic                    q_almost_full;
	fetch_pkg::instr_t       q_instr;
	fetch_pkg::data_t        q_pc;

	// a done from a flushed stream never reaches the queue
	assign accept        = done && !flush && !redirect_pending;
	assign fetched_ecall = (fix_order(rd_data) == fetch_pkg::ECALL);

	// no request in the done cycle, the pc only moves on that edge
	assign req      = (state == fetch_pkg::FETCH) && !busy && !done && !flush && !q_almost_full;
	assign req_addr = fetch_pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= fetch_pkg::IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		unique case (state)
			fetch_pkg::IDLE: begin
				if (go)
					state_nxt = fetch_pkg::FETCH;
			end
			fetch_pkg::FETCH: begin
				if (accept && fetched_ecall)
					state_nxt = fetch_pkg::ECALL_WAIT;
				else if (!busy && !flush && q_almost_full)
					state_nxt = fetch_pkg::HOLD;
			end
			fetch_pkg::HOLD: begin
				if (flush || !q_almost_full)
					state_nxt = fetch_pkg::FETCH;
			end
			fetch_pkg::ECALL_WAIT: begin
				// a flush here means the ecall was on a wrong path
				if (retire_instr == fetch_pkg::ECALL)
					state_nxt = fetch_pkg::IDLE;
				else if (flush)
					state_nxt = fetch_pkg::FETCH;
			end
			default: begin
				state_nxt = fetch_pkg::IDLE;
			end
		endcase
	end

	// after an ecall the pc already points past it, so go resumes there
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			fetch_pc <= fetch_pkg::data_t'(boot_pc);
		else if (flush)
			fetch_pc <= target;
		else if (accept)
			fetch_pc <= fetch_pc + fetch_pkg::data_t'(4);
	end

	// read in flight at flush time, drop its done
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			redirect_pending <= 1'b0;
		else if (flush && busy)
			redirect_pending <= 1'b1;
		else if (done)
			redirect_pending <= 1'b0;
	end

	assign q_rd_en = !stall && !flush && !q_empty;

	instr_queue u_queue (
		.clk         (clk),
		.rst_n       (rst_n),
		.clear       (flush),
		.wr_en       (accept),
		.wr_instr    (fetch_pkg::instr_t'(rd_data)),
		.wr_pc       (fetch_pc),
		.rd_en       (q_rd_en),
		.rd_instr    (q_instr),
		.rd_pc       (q_pc),
		.empty       (q_empty),
		.almost_full (q_almost_full),
		.count       ()
	);

	// lines up with the one-cycle read latency of the queue
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			instr_valid <= 1'b0;
		else if (flush)
			instr_valid <= 1'b0;
		else if (!stall)
			instr_valid <= !q_empty;
	end

	assign instr = instr_valid ? fix_order(fetch_pkg::data_t'(q_instr)) : fetch_pkg::NOP;
	assign pc    = instr_valid ? q_pc : '0;

endmodule

`default_nettype wire

// ==== fetch/instr_queue.sv ====
/* instruction queue: circular buffer of word and pc pairs with a
   registered read port, almost-full flag and single-cycle clear */
`timescale 1ns/1ps
`default_nettype none

module instr_queue (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire                                  clear,
	input  wire                                  wr_en,
	input  wire fetch_pkg::instr_t               wr_instr,
	input  wire fetch_pkg::data_t                wr_pc,
	input  wire                                  rd_en,
	output fetch_pkg::instr_t                    rd_instr,
	output fetch_pkg::data_t                     rd_pc,
	output logic                                 empty,
	output logic                                 almost_full,
	output logic [fetch_pkg::QUEUE_ADDR_WIDTH:0] count
);

	fetch_pkg::instr_t mem_instr [1 << fetch_pkg::QUEUE_ADDR_WIDTH];
	fetch_pkg::data_t  mem_pc    [1 << fetch_pkg::QUEUE_ADDR_WIDTH];

	// one extra bit tells full from empty
	logic [fetch_pkg::QUEUE_ADDR_WIDTH:0] wr_ptr;
	logic [fetch_pkg::QUEUE_ADDR_WIDTH:0] rd_ptr;
	logic full;
	logic do_wr;
	logic do_rd;

	assign count       = wr_ptr - rd_ptr;
	assign empty       = (count == '0);
	assign full        = count[fetch_pkg::QUEUE_ADDR_WIDTH];
	assign almost_full = (count >= fetch_pkg::QUEUE_ALMOST_FULL);

	assign do_wr = wr_en && !full && !clear;
	assign do_rd = rd_en && !empty && !clear;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem_instr[wr_ptr[fetch_pkg::QUEUE_ADDR_WIDTH-1:0]] <= wr_instr;
			mem_pc[wr_ptr[fetch_pkg::QUEUE_ADDR_WIDTH-1:0]]    <= wr_pc;
		end
	end

	// head shows up one cycle after the read
	always_ff @(posedge clk) begin
		if (do_rd) begin
			rd_instr <= mem_instr[rd_ptr[fetch_pkg::QUEUE_ADDR_WIDTH-1:0]];
			rd_pc    <= mem_pc[rd_ptr[fetch_pkg::QUEUE_ADDR_WIDTH-1:0]];
		end
	end

endmodule

`default_nettype wire

// ==== fetch_top.f ====
common/fetch_pkg.sv
fetch/instr_queue.sv
fetch/fetch_unit.sv
logic/axil_read_master.sv
logic/fetch_top.sv
testbench/tb_axil_mem.sv
testbench/tb_fetch_top.sv

// ==== logic/axil_read_master.sv ====
/* AXI-Lite read master: one fetch request becomes one read transaction,
   data returned registered with a done pulse */
`timescale 1ns/1ps
`default_nettype none

module axil_read_master (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          req,
	input  wire fetch_pkg::data_t        req_addr,
	input  wire                          arready,
	input  wire fetch_pkg::data_t        rdata,
	input  wire fetch_pkg::axil_resp_t   rresp,
	input  wire                          rvalid,
	output logic                         busy,
	output logic                         done,
	output fetch_pkg::data_t             rd_data,
	output fetch_pkg::data_t             araddr,
	output logic                         arvalid,
	output logic                         rready
);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_DATA,
		RD_DONE
	} rd_state_t;

	rd_state_t state;
	rd_state_t state_nxt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= RD_IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		unique case (state)
			RD_IDLE, RD_DONE: state_nxt = req ? RD_ADDR : RD_IDLE;
			RD_ADDR:          if (arready) state_nxt = RD_DATA;
			RD_DATA:          if (rvalid) state_nxt = RD_DONE;
			default:          state_nxt = RD_IDLE;
		endcase
	end

	// rresp is not checked, an instruction fetch has no fault path here
	always_ff @(posedge clk) begin
		if (req && !busy)
			araddr <= req_addr;
		if (state == RD_DATA && rvalid)
			rd_data <= rdata;
	end

	assign busy    = (state == RD_ADDR) || (state == RD_DATA);
	assign arvalid = (state == RD_ADDR);
	assign rready  = (state == RD_DATA);
	assign done    = (state == RD_DONE);

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
/* fetch top: instruction fetch unit joined to its AXI-Lite read master */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          go,
	input  wire fetch_pkg::boot_pc_t     boot_pc,
	input  wire                          stall,
	input  wire                          flush,
	input  wire fetch_pkg::data_t        target,
	input  wire fetch_pkg::instr_t       retire_instr,
	output fetch_pkg::instr_t            instr,
	output fetch_pkg::data_t             pc,
	output logic                         instr_valid,
	output fetch_pkg::data_t             araddr,
	output logic                         arvalid,
	input  wire                          arready,
	input  wire fetch_pkg::data_t        rdata,
	input  wire fetch_pkg::axil_resp_t   rresp,
	input  wire                          rvalid,
	output logic                         rready
);

	logic             req;
	fetch_pkg::data_t req_addr;
	logic             busy;
	logic             done;
	fetch_pkg::data_t rd_data;

	fetch_unit u_fetch (
		.clk          (clk),
		.rst_n        (rst_n),
		.go           (go),
		.boot_pc      (boot_pc),
		.stall        (stall),
		.flush        (flush),
		.target       (target),
		.retire_instr (retire_instr),
		.busy         (busy),
		.done         (done),
		.rd_data      (rd_data),
		.req          (req),
		.req_addr     (req_addr),
		.instr        (instr),
		.pc           (pc),
		.instr_valid  (instr_valid)
	);

	axil_read_master u_axil (
		.clk      (clk),
		.rst_n    (rst_n),
		.req      (req),
		.req_addr (req_addr),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.busy     (busy),
		.done     (done),
		.rd_data  (rd_data),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.rready   (rready)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f fetch_top.f --top-module tb_fetch_top \
	-Mdir obj_dir -o sim_fetch_top
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_fetch_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" sim.log; then
	exit 1
fi
exit 0

// ==== testbench/tb_axil_mem.sv ====
/* AXI-Lite read slave model: random ready and data delays, word computed
   from the address with an ecall at a chosen address */
`timescale 1ns/1ps
`default_nettype none

module tb_axil_mem (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        slow,
	input  wire fetch_pkg::data_t      ecall_addr,
	input  wire fetch_pkg::data_t      araddr,
	input  wire                        arvalid,
	output logic                       arready,
	output fetch_pkg::data_t           rdata,
	output fetch_pkg::axil_resp_t      rresp,
	output logic                       rvalid,
	input  wire                        rready
);

	integer           seed = 32'hd22d18c4;
	logic [1:0]       phase;
	int               delay;
	fetch_pkg::data_t addr;
	fetch_pkg::data_t word;

	function automatic int pick_delay();
		return slow ? int'($unsigned($random(seed)) % 6) : int'($unsigned($random(seed)) % 2);
	endfunction

	// the bus carries each instruction with its bytes reversed
	always_comb begin
		word = (addr == ecall_addr) ? fetch_pkg::ECALL : addr * 32'd3 + 32'd1;
	end

	assign rresp = '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			addr    <= '0;
			delay   <= 0;
			phase   <= 2'd0;
		end else begin
			case (phase)
				2'd0: begin
					if (arvalid && arready) begin
						arready <= 1'b0;
						addr    <= araddr;
						delay   <= pick_delay();
						phase   <= 2'd1;
					end else if (arvalid) begin
						if (delay == 0)
							arready <= 1'b1;
						else
							delay <= delay - 1;
					end
				end
				2'd1: begin
					if (delay == 0) begin
						rvalid <= 1'b1;
						rdata  <= {word[7:0], word[15:8], word[23:16], word[31:24]};
						phase  <= 2'd2;
					end else begin
						delay <= delay - 1;
					end
				end
				default: begin
					if (rvalid && rready) begin
						rvalid <= 1'b0;
						delay  <= pick_delay();
						phase  <= 2'd0;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_fetch_top.sv ====
/* testbench for the fetch top: random stall, flush and go stimulus
   checked against a model of the issued instruction stream */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS  = 5;
	localparam int MAX_CYCLES = 800;

	logic                  clk;
	logic                  rst_n;
	logic                  go;
	logic                  stall;
	logic                  flush;
	logic                  slow;
	fetch_pkg::boot_pc_t   boot_pc;
	fetch_pkg::data_t      target;
	fetch_pkg::data_t      pc;
	fetch_pkg::data_t      araddr;
	fetch_pkg::data_t      rdata;
	fetch_pkg::data_t      ecall_addr;
	fetch_pkg::data_t      exp_pc;
	fetch_pkg::data_t      prev_pc;
	fetch_pkg::data_t      exp_ar_addr;
	fetch_pkg::data_t      after_ar;
	fetch_pkg::instr_t     retire_instr;
	fetch_pkg::instr_t     instr;
	fetch_pkg::instr_t     prev_instr;
	fetch_pkg::axil_resp_t rresp;
	logic                  instr_valid;
	logic                  arvalid;
	logic                  arready;
	logic                  rvalid;
	logic                  rready;
	logic                  ecall_wait;
	logic                  ecall_seen;
	logic                  prev_valid;
	logic                  prev_stall;
	logic                  prev_flush;
	logic                  redirect_after;
	integer                seed;
	int                    error_count;
	int                    failed_tests;
	int                    consumed;
	int                    ar_count;

	fetch_top u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.go           (go),
		.boot_pc      (boot_pc),
		.stall        (stall),
		.flush        (flush),
		.target       (target),
		.retire_instr (retire_instr),
		.instr        (instr),
		.pc           (pc),
		.instr_valid  (instr_valid),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready)
	);

	tb_axil_mem u_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.slow       (slow),
		.ecall_addr (ecall_addr),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// instruction expected at an address once byte order is restored
	function automatic fetch_pkg::instr_t model_word(input fetch_pkg::data_t a);
		return (a == ecall_addr) ? fetch_pkg::ECALL : a * 32'd3 + 32'd1;
	endfunction

	task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] want);
		$display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
		error_count++;
	endtask

	// outputs are stable at the falling edge
	task automatic check_outputs(input bit check_ar);
		int queued;
		queued = ar_count - consumed - (instr_valid ? 1 : 0);
		if (!instr_valid && instr !== fetch_pkg::NOP)
			report_value("instr", instr, fetch_pkg::NOP);
		if (!instr_valid && pc !== '0)
			report_value("pc", pc, '0);
		if (prev_stall && !prev_flush) begin
			if (instr_valid !== prev_valid)
				report_value("instr_valid", instr_valid, prev_valid);
			if (prev_valid && instr !== prev_instr)
				report_value("instr", instr, prev_instr);
			if (prev_valid && pc !== prev_pc)
				report_value("pc", pc, prev_pc);
		end
		if (instr_valid && ecall_wait) begin
			$display("Error at %0t: instruction issued before the ecall retired", $time);
			error_count++;
		end else if (instr_valid) begin
			if (pc !== exp_pc)
				report_value("pc", pc, exp_pc);
			if (instr !== model_word(exp_pc))
				report_value("instr", instr, model_word(exp_pc));
		end
		if (arvalid && arready) begin
			if (araddr !== exp_ar_addr)
				report_value("araddr", araddr, exp_ar_addr);
			exp_ar_addr    = redirect_after ? after_ar : exp_ar_addr + 32'd4;
			redirect_after = 1'b0;
			if (check_ar && queued >= fetch_pkg::QUEUE_ALMOST_FULL) begin
				$display("Error at %0t: read request with %0d entries queued", $time, queued);
				error_count++;
			end
			ar_count++;
		end
	endtask

	task automatic drive_cycle(input int stall_pct, input int flush_pct, input bit hold,
	                           input bit retire, input bit wake);
		bit s;
		bit f;
		fetch_pkg::data_t t;
		s = hold || (int'($unsigned($random(seed)) % 100) < stall_pct);
		f = int'($unsigned($random(seed)) % 100) < flush_pct;
		t = $unsigned($random(seed)) & 32'h0000_fffc;
		prev_valid = instr_valid;
		prev_instr = instr;
		prev_pc    = pc;
		prev_stall = s;
		prev_flush = f;
		stall        = s;
		flush        = f;
		target       = t;
		retire_instr = retire ? fetch_pkg::ECALL : fetch_pkg::NOP;
		go           = wake;
		if (f) begin
			exp_pc = t;
			// a read already presented on AR still carries the old address
			if (arvalid && !arready) begin
				after_ar       = t;
				redirect_after = 1'b1;
			end else begin
				exp_ar_addr = t;
			end
		end else if (instr_valid && !s) begin
			consumed++;
			if (exp_pc == ecall_addr) begin
				ecall_wait = 1'b1;
				ecall_seen = 1'b1;
			end
			exp_pc = exp_pc + 32'd4;
		end
	endtask

	task automatic step(input int stall_pct, input int flush_pct, input bit hold,
	                    input bit retire, input bit wake, input bit check_ar);
		@(negedge clk);
		check_outputs(check_ar);
		drive_cycle(stall_pct, flush_pct, hold, retire, wake);
	endtask

	task automatic run_test(input int num, input string name, input int stall_pct,
	                        input int flush_pct, input bit slow_slave, input bit use_ecall,
	                        input bit long_stall, input int goal);
		int cycles;
		int errors_before;
		errors_before = error_count;
		@(negedge clk);
		rst_n   = 1'b0;
		go      = 1'b0;
		stall   = 1'b0;
		flush   = 1'b0;
		slow    = slow_slave;
		boot_pc = fetch_pkg::boot_pc_t'($unsigned($random(seed))) & 10'h3fc;
		ecall_addr = use_ecall ? 32'(boot_pc) + 32'd24 : 32'hffff_fffc;
		repeat (3) @(negedge clk);
		// bus and issue outputs quiet while reset is held
		if (arvalid !== 1'b0)
			report_value("arvalid", arvalid, 1'b0);
		if (rready !== 1'b0)
			report_value("rready", rready, 1'b0);
		if (instr_valid !== 1'b0)
			report_value("instr_valid", instr_valid, 1'b0);
		rst_n = 1'b1;
		exp_pc = 32'(boot_pc);
		exp_ar_addr    = 32'(boot_pc);
		redirect_after = 1'b0;
		consumed   = 0;
		ar_count   = 0;
		ecall_wait = 1'b0;
		ecall_seen = 1'b0;
		drive_cycle(0, 0, 1'b0, 1'b0, 1'b1);
		cycles = 0;
		while (consumed < goal && cycles < MAX_CYCLES) begin
			if (ecall_wait) begin
				// neither go alone nor the retire alone may wake fetch
				repeat (4) step(0, 0, 1'b0, 1'b0, 1'b0, 1'b0);
				step(0, 0, 1'b0, 1'b0, 1'b1, 1'b0);
				repeat (12) step(0, 0, 1'b0, 1'b0, 1'b0, 1'b0);
				step(0, 0, 1'b0, 1'b1, 1'b0, 1'b0);
				repeat (12) step(0, 0, 1'b0, 1'b0, 1'b0, 1'b0);
				step(0, 0, 1'b0, 1'b0, 1'b1, 1'b0);
				ecall_wait = 1'b0;
				cycles += 31;
			end else begin
				step(stall_pct, flush_pct, long_stall && cycles >= 10 && cycles < 70,
				     1'b0, 1'b0, long_stall);
				cycles++;
			end
		end
		if (consumed < goal) begin
			$display("Error: test %0d stopped after %0d of %0d instructions", num, consumed, goal);
			error_count++;
		end
		if (use_ecall && !ecall_seen) begin
			$display("Error: test %0d never issued the ecall", num);
			error_count++;
		end
		if (error_count == errors_before) begin
			$display("test %0d %s: pass, %0d instructions", num, name, consumed);
		end else begin
			failed_tests++;
			$display("test %0d %s: FAIL, %0d errors", num, name, error_count - errors_before);
		end
	endtask

	initial begin
		seed = 32'hd22d18c4;
		rst_n = 1'b0;
		go = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		slow = 1'b0;
		boot_pc = '0;
		target = '0;
		retire_instr = fetch_pkg::NOP;
		ecall_addr = 32'hffff_fffc;
		error_count = 0;
		failed_tests = 0;
		run_test(1, "sequential issue", 0, 0, 1'b0, 1'b0, 1'b0, 24);
		run_test(2, "random stall, slow slave", 40, 0, 1'b1, 1'b0, 1'b0, 30);
		run_test(3, "random flush", 25, 6, 1'b0, 1'b0, 1'b0, 40);
		run_test(4, "ecall stop", 20, 0, 1'b0, 1'b1, 1'b0, 16);
		run_test(5, "long stall", 15, 0, 1'b1, 1'b0, 1'b1, 24);
		$display("tests run: %0d, failed: %0d, errors: %0d", NUM_TESTS, failed_tests, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		#(NUM_TESTS * (MAX_CYCLES + 40) * CLK_PERIOD);
		$display("Error: watchdog expired, the run did not complete");
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire
